/* hw/rob_alloc_ctrl.sv */
/*
 * Allocation controller for the reorder buffer
 * Newest and oldest ring pointers, full flag and valid tag
 * Registered write stage that tags each write and steers it to a valid bank
 */

`timescale 1ns/1ps

module rob_alloc_ctrl
    import rob_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         alloc,
    input  logic         deq_en,
    input  logic         wr_en,
    input  idx_t         wr_idx,
    output logic         not_full,
    output idx_t         alloc_idx,
    output idx_t         oldest,
    rob_valid_if.writer  banks [N_BANKS]
);

    // ==============================
    // Ring pointers
    // ==============================

    idx_t newest;
    // Tag that marks an entry valid on the current trip of the oldest pointer
    logic valid_tag;

    // The ring counts as full when one more allocation would land on the oldest entry
    assign not_full  = (newest + idx_t'(1)) != oldest;
    assign alloc_idx = newest;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            newest    <= '0;
            oldest    <= '0;
            valid_tag <= 1'b1;
        end
        else
        begin
            if (alloc)
                newest <= newest + idx_t'(1);
            if (deq_en)
            begin
                oldest <= oldest + idx_t'(1);
                // Retiring the last index starts a new trip, so the meaning of the tag flips
                if (&oldest)
                    valid_tag <= ~valid_tag;
            end
        end
    end

    // ==============================
    // Write tagging and steering
    // ==============================

    logic wr_en_q;
    idx_t wr_idx_q;
    logic wtag_q;

    // Indices below the oldest pointer already belong to the next trip
    always_ff @(posedge clk)
    begin
        wr_idx_q <= wr_idx;
        wtag_q   <= (wr_idx >= oldest) ? valid_tag : ~valid_tag;
        if (reset)
            wr_en_q <= 1'b0;
        else
            wr_en_q <= wr_en;
    end

    // Low index bit picks the bank, the remaining bits address within it
    for (genvar b = 0; b < N_BANKS; b++)
    begin : g_steer
        assign banks[b].wen   = wr_en_q && (wr_idx_q[0] == b[0]);
        assign banks[b].waddr = wr_idx_q[IDX_BITS-1:1];
        assign banks[b].wtag  = wtag_q;
    end

endmodule

/* hw/rob_pkg.sv */
/*
 * Shared sizes and types for the reorder buffer
 * Entry count, payload and meta-data widths, valid bank count
 * Index, bank address, payload and ready counter types
 */

package rob_pkg;

    // ==============================
    // Sizes
    // ==============================

    // Number of ring entries, kept a power of two so the pointers wrap for free
    localparam int ROB_ENTRIES = 16;
    localparam int DATA_BITS   = 32;
    localparam int META_BITS   = 8;

    // Valid bits are split into banks by the low index bit
    localparam int N_BANKS     = 2;
    localparam int IDX_BITS    = $clog2(ROB_ENTRIES);
    localparam int BANK_DEPTH  = ROB_ENTRIES / N_BANKS;

    // Largest value the ready counter may hold
    localparam int READY_MAX   = 7;

    // ==============================
    // Types
    // ==============================

    typedef logic [IDX_BITS-1:0]  idx_t;
    // Entry index with the bank select bit removed
    typedef logic [IDX_BITS-2:0]  bank_addr_t;
    typedef logic [DATA_BITS-1:0] data_t;
    typedef logic [META_BITS-1:0] meta_t;
    typedef logic [2:0]           ready_cnt_t;

endpackage

/* hw/rob_ready_tracker.sv */
/*
 * Ready tracker for the reorder buffer
 * Scans the two valid banks in turn, in ring order
 * Counts entries whose data has arrived and drives not_empty
 */

`timescale 1ns/1ps

module rob_ready_tracker
    import rob_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         deq_en,
    output logic         not_empty,
    rob_valid_if.reader  banks [N_BANKS]
);

    // Per-bank scan index, the bank under test and the tag it must match
    bank_addr_t rd_idx [N_BANKS];
    logic       bank_sel;
    logic       target_tag;
    ready_cnt_t ready_cnt;

    // Bank read bits gathered into a vector so the selected one can be picked
    logic [N_BANKS-1:0] rd_bits;

    for (genvar b = 0; b < N_BANKS; b++)
    begin : g_scan
        assign banks[b].raddr = rd_idx[b];
        assign rd_bits[b]     = banks[b].rdata;
    end

    // ==============================
    // Readiness test
    // ==============================

    // The next entry in ring order is ready when its bit carries this trip's tag
    // Counting stops at the saturation point and resumes once entries drain
    logic becomes_ready;

    assign becomes_ready = (rd_bits[bank_sel] == target_tag) &&
                           (ready_cnt != ready_cnt_t'(READY_MAX));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int b = 0; b < N_BANKS; b++)
                rd_idx[b] <= '0;
            bank_sel   <= 1'b0;
            target_tag <= 1'b1;
        end
        else if (becomes_ready)
        begin
            rd_idx[bank_sel] <= rd_idx[bank_sel] + bank_addr_t'(1);
            // Entries alternate banks, so the next one lives in the other bank
            bank_sel <= ~bank_sel;
            // Passing the last entry of bank 1 completes a trip around the ring
            if (bank_sel && (&rd_idx[1]))
                target_tag <= ~target_tag;
        end
    end

    // ==============================
    // Ready count and not_empty
    // ==============================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ready_cnt <= '0;
            not_empty <= 1'b0;
        end
        else
        begin
            ready_cnt <= ready_cnt - ready_cnt_t'(deq_en) + ready_cnt_t'(becomes_ready);
            // Non-zero next count, without waiting for the counter itself
            not_empty <= becomes_ready ||
                         (ready_cnt > ready_cnt_t'(1)) ||
                         ((ready_cnt == ready_cnt_t'(1)) && !deq_en);
        end
    end

endmodule

/* hw/rob_storage.sv */
/*
 * Payload storage for the reorder buffer
 * Data memory with a registered write, meta-data memory written at allocation
 * Both read at the oldest index through two output registers
 */

`timescale 1ns/1ps

module rob_storage
    import rob_pkg::*;
(
    input  logic  clk,
    input  logic  alloc,
    input  idx_t  alloc_idx,
    input  meta_t alloc_meta,
    input  logic  wr_en,
    input  idx_t  wr_idx,
    input  data_t wr_data,
    input  idx_t  oldest,
    output data_t first,
    output meta_t first_meta
);

    data_t data_mem [ROB_ENTRIES];
    meta_t meta_mem [ROB_ENTRIES];

    // Write stage, so data lands in step with its valid bit
    logic  wr_en_q;
    idx_t  wr_idx_q;
    data_t wr_data_q;

    // Two read stages give the fixed dequeue latency
    data_t data_s1;
    meta_t meta_s1;

    always_ff @(posedge clk)
    begin
        wr_en_q   <= wr_en;
        wr_idx_q  <= wr_idx;
        wr_data_q <= wr_data;
        if (wr_en_q)
            data_mem[wr_idx_q] <= wr_data_q;
        if (alloc)
            meta_mem[alloc_idx] <= alloc_meta;
        data_s1    <= data_mem[oldest];
        meta_s1    <= meta_mem[oldest];
        first      <= data_s1;
        first_meta <= meta_s1;
    end

endmodule

/* hw/rob_top.sv */
/*
 * Reorder buffer top level
 * Allocation controller, two valid banks, ready tracker and payload storage
 */

`timescale 1ns/1ps

module rob_top
    import rob_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  alloc,
    input  meta_t alloc_meta,
    output logic  not_full,
    output idx_t  alloc_idx,
    input  logic  wr_en,
    input  idx_t  wr_idx,
    input  data_t wr_data,
    input  logic  deq_en,
    output logic  not_empty,
    output data_t first,
    output meta_t first_meta
);

    // Oldest allocated index, shared by the controller and storage
    idx_t oldest;

    // One link per valid bank
    rob_valid_if valid_if [N_BANKS] ();

    rob_alloc_ctrl i_alloc_ctrl (
        .clk       (clk),
        .reset     (reset),
        .alloc     (alloc),
        .deq_en    (deq_en),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .not_full  (not_full),
        .alloc_idx (alloc_idx),
        .oldest    (oldest),
        .banks     (valid_if)
    );

    // ==============================
    // Valid banks
    // ==============================

    for (genvar b = 0; b < N_BANKS; b++)
    begin : g_bank
        rob_valid_bank i_valid_bank (
            .clk   (clk),
            .reset (reset),
            .port  (valid_if[b])
        );
    end

    rob_ready_tracker i_ready_tracker (
        .clk       (clk),
        .reset     (reset),
        .deq_en    (deq_en),
        .not_empty (not_empty),
        .banks     (valid_if)
    );

    rob_storage i_storage (
        .clk        (clk),
        .alloc      (alloc),
        .alloc_idx  (alloc_idx),
        .alloc_meta (alloc_meta),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .oldest     (oldest),
        .first      (first),
        .first_meta (first_meta)
    );

endmodule

/* hw/rob_valid_bank.sv */
/*
 * One bank of tagged valid bits
 * Flip-flop array cleared by reset, synchronous write
 * Registered read that forwards a same-cycle write to the read address
 */

`timescale 1ns/1ps

module rob_valid_bank
    import rob_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    rob_valid_if.bank port
);

    // One tag bit per entry of this bank
    logic [BANK_DEPTH-1:0] tag_bits;

    // A write that hits the address being read is seen at once
    logic hit;
    logic rd_bit;

    assign hit    = port.wen && (port.waddr == port.raddr);
    assign rd_bit = hit ? port.wtag : tag_bits[port.raddr];

    // ==============================
    // Bit array and read register
    // ==============================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            // All bits start at 0, so the first trip looks for a tag of 1
            tag_bits   <= '0;
            port.rdata <= 1'b0;
        end
        else
        begin
            if (port.wen)
                tag_bits[port.waddr] <= port.wtag;
            port.rdata <= rd_bit;
        end
    end

    // Bits are never cleared on dequeue
    // The tag written on the next trip simply has the other polarity

endmodule

/* hw/rob_valid_if.sv */
/*
 * Link between the allocation controller, one valid bank and the ready tracker
 * Write side carries the tagged valid update, read side scans the bank
 */

`timescale 1ns/1ps

interface rob_valid_if
    import rob_pkg::*;
();

    // Tagged valid bit update, one cycle after the data write
    logic       wen;
    bank_addr_t waddr;
    logic       wtag;

    // Scan address from the tracker and the registered bit it returns
    bank_addr_t raddr;
    logic       rdata;

    // Allocation controller steers writes into the bank
    modport writer (output wen, output waddr, output wtag);

    // Ready tracker presents an address and sees the bit a cycle later
    modport reader (output raddr, input rdata);

    // The bank itself
    modport bank (input wen, input waddr, input wtag, input raddr, output rdata);

endinterface

/* list.f */
hw/rob_pkg.sv
hw/rob_valid_if.sv
hw/rob_alloc_ctrl.sv
hw/rob_valid_bank.sv
hw/rob_ready_tracker.sv
hw/rob_storage.sv
hw/rob_top.sv
verif/rob_tb.sv

/* run.sh */
#!/bin/sh
# Build the reorder buffer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module rob_tb -o rob_sim

out=$(./obj_dir/rob_sim)
echo "$out"

if echo "$out" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

/* verif/rob_tb.sv */
/*
 * Testbench for the reorder buffer
 * Clock, reset and random stimulus from a fixed seed
 * Queue model of allocated entries, typed compare tasks and final report
 */

`timescale 1ns/1ps

module rob_tb
    import rob_pkg::*;
();

    logic  clk = 1'b0;
    logic  reset;
    logic  alloc;
    meta_t alloc_meta;
    logic  not_full;
    idx_t  alloc_idx;
    logic  wr_en;
    idx_t  wr_idx;
    data_t wr_data;
    logic  deq_en;
    logic  not_empty;
    data_t first;
    meta_t first_meta;

    // One allocated entry as the model sees it
    typedef struct packed {
        idx_t  idx;
        meta_t meta;
        data_t data;
        logic  written;
    } entry_t;

    // Entries in allocation order with the oldest at the head
    entry_t model_q[$];
    idx_t   next_idx = '0;

    // Dequeued entries on their way to the outputs through two stages
    entry_t pend;
    entry_t stage0;
    entry_t stage1;
    logic   pend_v = 1'b0;
    logic   stage0_v = 1'b0;
    logic   stage1_v = 1'b0;

    int    errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    test_start_errors = 0;
    string test_name = "setup";

    always #5 clk = ~clk;

    rob_top i_rob_top (
        .clk        (clk),
        .reset      (reset),
        .alloc      (alloc),
        .alloc_meta (alloc_meta),
        .not_full   (not_full),
        .alloc_idx  (alloc_idx),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .deq_en     (deq_en),
        .not_empty  (not_empty),
        .first      (first),
        .first_meta (first_meta)
    );

    // ==============================
    // Compare tasks
    // ==============================

    task automatic check_data(input string what, input data_t actual, input data_t expected);
        if (actual !== expected)
        begin
            errors++;
            $display("** Error %s: %s expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic check_meta(input string what, input meta_t actual, input meta_t expected);
        if (actual !== expected)
        begin
            errors++;
            $display("** Error %s: %s expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic check_idx(input string what, input idx_t actual, input idx_t expected);
        if (actual !== expected)
        begin
            errors++;
            $display("** Error %s: %s expected %0d, actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic check_flag(input string what, input bit actual, input bit expected);
        if (actual !== expected)
        begin
            errors++;
            $display("** Error %s: %s expected %0b, actual %0b",
                     test_name, what, expected, actual);
        end
    endtask

    // ==============================
    // Cycle stepping and model
    // ==============================

    // Advance one clock, check what is due, then release the inputs 1 ns after the edge
    task automatic next_cycle();
        entry_t head;
        @(posedge clk);
        #1;
        stage1   = stage0;
        stage1_v = stage0_v;
        stage0   = pend;
        stage0_v = pend_v;
        pend_v   = 1'b0;
        // The entry dequeued two edges ago must be on the outputs now
        if (stage1_v)
        begin
            check_data("first", first, stage1.data);
            check_meta("first_meta", first_meta, stage1.meta);
        end
        // Full when one more allocation would reach the oldest entry
        check_flag("not_full", not_full, model_q.size() < ROB_ENTRIES - 1);
        if (not_empty)
        begin
            if (model_q.size() == 0)
            begin
                errors++;
                $display("Error in %s: not_empty is high with no entry allocated", test_name);
            end
            else
            begin
                head = model_q[0];
                if (!head.written)
                begin
                    errors++;
                    $display("Error in %s: not_empty is high before the oldest entry has data",
                             test_name);
                end
            end
        end
        alloc  = 1'b0;
        wr_en  = 1'b0;
        deq_en = 1'b0;
    endtask

    task automatic alloc_entry();
        entry_t e;
        check_idx("alloc_idx", alloc_idx, next_idx);
        e.idx     = next_idx;
        e.meta    = meta_t'($urandom);
        e.data    = data_t'($urandom);
        e.written = 1'b0;
        model_q.push_back(e);
        next_idx   = next_idx + idx_t'(1);
        alloc      = 1'b1;
        alloc_meta = e.meta;
    endtask

    task automatic write_entry(input int pos);
        entry_t e;
        e         = model_q[pos];
        e.written = 1'b1;
        model_q[pos] = e;
        wr_en   = 1'b1;
        wr_idx  = e.idx;
        wr_data = e.data;
    endtask

    task automatic dequeue_head();
        pend   = model_q.pop_front();
        pend_v = 1'b1;
        deq_en = 1'b1;
    endtask

    // Returns the position of a random entry still waiting for data or -1 when there is none
    function automatic int pick_unwritten();
        int     cand[$];
        entry_t e;
        for (int i = 0; i < model_q.size(); i++)
        begin
            e = model_q[i];
            if (!e.written)
                cand.push_back(i);
        end
        if (cand.size() == 0)
            return -1;
        return cand[$urandom % cand.size()];
    endfunction

    task automatic wait_not_empty();
        int n;
        n = 0;
        while (!not_empty && n < 200)
        begin
            next_cycle();
            n++;
        end
        if (!not_empty)
        begin
            errors++;
            $display("Timeout in %s: not_empty did not rise within 200 cycles", test_name);
        end
    endtask

    // Dequeue n entries as they become ready, then let the last one reach the outputs
    task automatic deq_all(input int n);
        for (int i = 0; i < n; i++)
        begin
            wait_not_empty();
            if (not_empty)
                dequeue_head();
            next_cycle();
        end
        repeat (2) next_cycle();
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_start_errors = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == test_start_errors)
            $display("Test %s: PASS", test_name);
        else
        begin
            tests_failed++;
            $display("Test %s: FAIL, %0d errors", test_name, errors - test_start_errors);
        end
    endtask

    // ==============================
    // Tests
    // ==============================

    task automatic reset_state();
        begin_test("reset_state");
        check_flag("not_empty", not_empty, 1'b0);
        check_flag("not_full", not_full, 1'b1);
        check_idx("alloc_idx", alloc_idx, idx_t'(0));
        end_test();
    endtask

    task automatic in_order_return();
        begin_test("in_order_return");
        for (int i = 0; i < 6; i++)
        begin
            alloc_entry();
            next_cycle();
        end
        for (int i = 0; i < 6; i++)
        begin
            write_entry(i);
            next_cycle();
        end
        wait_not_empty();
        deq_all(6);
        end_test();
    endtask

    task automatic out_of_order_return();
        int perm[7];
        int j;
        int t;
        begin_test("out_of_order_return");
        for (int i = 0; i < 8; i++)
        begin
            alloc_entry();
            next_cycle();
        end
        for (int i = 0; i < 7; i++)
            perm[i] = i + 1;
        // Shuffle the younger entries and keep the oldest one for last
        for (int i = 6; i > 0; i--)
        begin
            j       = $urandom % (i + 1);
            t       = perm[i];
            perm[i] = perm[j];
            perm[j] = t;
        end
        for (int i = 0; i < 7; i++)
        begin
            write_entry(perm[i]);
            next_cycle();
            check_flag("not_empty", not_empty, 1'b0);
        end
        repeat (4)
        begin
            next_cycle();
            check_flag("not_empty", not_empty, 1'b0);
        end
        write_entry(0);
        next_cycle();
        deq_all(8);
        end_test();
    endtask

    task automatic full_flag();
        int n;
        int pos;
        begin_test("full_flag");
        n = 0;
        while (not_full && n < 200)
        begin
            alloc_entry();
            next_cycle();
            n++;
        end
        if (not_full)
        begin
            errors++;
            $display("Timeout in %s: not_full did not fall within 200 allocations", test_name);
        end
        else
            check_idx("allocations before full", idx_t'(n), idx_t'(ROB_ENTRIES - 1));
        write_entry(0);
        next_cycle();
        wait_not_empty();
        dequeue_head();
        next_cycle();
        check_flag("not_full after one dequeue", not_full, 1'b1);
        pos = pick_unwritten();
        while (pos >= 0)
        begin
            write_entry(pos);
            next_cycle();
            pos = pick_unwritten();
        end
        deq_all(model_q.size());
        end_test();
    endtask

    task automatic random_traffic();
        int pos;
        int n;
        begin_test("random_traffic");
        for (int c = 0; c < 2000; c++)
        begin
            pos = pick_unwritten();
            if (pos >= 0 && $urandom % 4 != 0)
                write_entry(pos);
            if (not_empty && $urandom % 2 == 0)
                dequeue_head();
            if (not_full && $urandom % 2 == 0)
                alloc_entry();
            next_cycle();
        end
        // Drain the ring and supply data for whatever is still outstanding
        n = 0;
        while (model_q.size() > 0 && n < 200)
        begin
            pos = pick_unwritten();
            if (pos >= 0)
                write_entry(pos);
            if (not_empty)
                dequeue_head();
            next_cycle();
            n++;
        end
        if (model_q.size() > 0)
        begin
            errors++;
            $display("Timeout in %s: %0d entries left after 200 drain cycles",
                     test_name, model_q.size());
        end
        repeat (2) next_cycle();
        check_flag("not_empty when drained", not_empty, 1'b0);
        end_test();
    endtask

    initial
    begin
        void'($urandom(20));
        reset      = 1'b1;
        alloc      = 1'b0;
        alloc_meta = '0;
        wr_en      = 1'b0;
        wr_idx     = '0;
        wr_data    = '0;
        deq_en     = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        reset_state();
        in_order_return();
        out_of_order_return();
        full_flag();
        random_traffic();
        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
